/* source/adc_acq_params.svh */
`ifndef ADC_ACQ_PARAMS_SVH
`define ADC_ACQ_PARAMS_SVH

// datapath widths
`define ADC_ACQ_DAT_W   32  // stream word / adc sample width
`define ADC_ACQ_ADDR_W  24  // fill address counter
`define ADC_ACQ_BURST_W 16  // bursts per fill
`define ADC_ACQ_FILL_W  14  // fill counter, also fits in the header

// wishbone side
`define ADC_ACQ_WB_ADR_W 5  // byte address, covers 0x00..0x1f

// register map, byte addresses
`define ADC_ACQ_REG_SIZE1  5'h00  // bursts for fill type A
`define ADC_ACQ_REG_SIZE2  5'h04  // bursts for fill type B
`define ADC_ACQ_REG_SIZE3  5'h08  // bursts for fill type C
`define ADC_ACQ_REG_CTRL   5'h0c  // bit 0 dummy data select
`define ADC_ACQ_REG_STATUS 5'h10  // read only, fill count and idle

// burst count loaded into all three size registers at reset
`define ADC_ACQ_SIZE_RST 16'd4

`endif

/* source/adc_acq_pkg.sv */
`include "adc_acq_params.svh"

package adc_acq_pkg;

	// fill type comes straight from the enable pair, {enable1, enable0}
	typedef enum logic [1:0] {
		FILL_READOUT = 2'd0,  // both enables low, no triggers taken
		FILL_A       = 2'd1,
		FILL_B       = 2'd2,
		FILL_C       = 2'd3
	} fill_type_t;

	// one-hot sequencer states
	typedef enum logic [11:0] {
		IDLE      = 12'h001,
		INIT1     = 12'h002,
		INIT2     = 12'h004,
		INIT3     = 12'h008,
		RUN1      = 12'h010,
		RUN2      = 12'h020,
		RUN3      = 12'h040,
		RUN4      = 12'h080,
		CHECKSUM1 = 12'h100,
		CHECKSUM2 = 12'h200,
		DDR3_WAIT = 12'h400,
		DONE      = 12'h800
	} acq_state_t;

	typedef enum logic [1:0] {
		WORD_HEADER   = 2'd0,
		WORD_DATA     = 2'd1,
		WORD_CHECKSUM = 2'd2
	} word_kind_t;

	// synchronized inputs, as seen by the sequencer and the formatter
	typedef struct packed {
		logic       mode_enabled;  // armed for triggers
		logic       trig;
		logic       ddr3_busy;     // downstream writer not idle
		fill_type_t fill_type;
	} acq_sync_t;

	// strobes from the sequencer, each valid in the first cycle of its state
	typedef struct packed {
		logic       fill_size_latch;
		logic       burst_init;
		logic       burst_dec;
		logic       addr_inc;
		logic       fill_inc;
		logic       dummy_reset;
		word_kind_t word_kind;  // which word the mux prepares
		logic       out_valid;  // emit the prepared word
		logic       done;
		logic       idle;
	} acq_ctrl_t;

	// one word of the output stream
	typedef struct packed {
		logic                       valid;
		word_kind_t                 kind;
		logic [`ADC_ACQ_ADDR_W-1:0] addr;
		logic [`ADC_ACQ_DAT_W-1:0]  data;
	} acq_word_t;

endpackage

/* source/adc_acq_decode.sv */
`timescale 1ns/1ps

module adc_acq_decode
	import adc_acq_pkg::*;
(
	input  logic      clk,
	input  logic      adc_acq_full_reset,
	input  logic      acq_enable0,   // async, from the master
	input  logic      acq_enable1,   // async, from the master
	input  logic      acq_trig,      // async trigger
	input  logic      ddr3_wr_busy,  // async, from the ddr3 writer's domain
	output acq_sync_t sync
);

	// bit order {busy, trig, enable1, enable0}
	logic [3:0] meta_q;  // first sync stage, may go metastable
	logic [3:0] stab_q;  // second sync stage

	// two-flop synchronizers on the async pins
	always_ff @(posedge clk) begin
		meta_q <= {ddr3_wr_busy, acq_trig, acq_enable1, acq_enable0};
		stab_q <= meta_q;
	end

	// decode stage, third register after the pins
	always_ff @(posedge clk) begin
		if (adc_acq_full_reset) begin
			sync <= '{
				mode_enabled: 1'b0,
				trig:         1'b0,
				ddr3_busy:    1'b0,
				fill_type:    FILL_READOUT
			};
		end else begin
			sync.mode_enabled <= stab_q[0] | stab_q[1];  // not both zero means acquisition mode
			sync.trig         <= stab_q[2];
			sync.ddr3_busy    <= stab_q[3];
			sync.fill_type    <= fill_type_t'(stab_q[1:0]);  // enable1 is the high bit
		end
	end

endmodule

/* source/adc_acq_sm.sv */
`timescale 1ns/1ps

module adc_acq_sm
	import adc_acq_pkg::*;
(
	input  logic      clk,
	input  logic      adc_acq_full_reset,
	input  acq_sync_t sync,
	input  logic      burst_zero,  // last burst of the fill has been counted
	output acq_ctrl_t ctrl
);

	acq_state_t state_q;
	acq_state_t state_nxt;
	acq_ctrl_t  ctrl_nxt;
	logic       armed_trig;  // enabled and triggered

	assign armed_trig = sync.mode_enabled & sync.trig;

	always_ff @(posedge clk) begin
		if (adc_acq_full_reset)
			state_q <= IDLE;
		else
			state_q <= state_nxt;
	end

	// next state
	always_comb begin
		state_nxt = state_q;
		case (state_q)
			IDLE:      if (armed_trig) state_nxt = INIT1;  // wait to be armed and triggered
			INIT1:     state_nxt = INIT2;
			INIT2:     state_nxt = INIT3;
			INIT3:     state_nxt = RUN1;
			RUN1:      state_nxt = RUN2;
			RUN2:      state_nxt = RUN3;
			RUN3:      state_nxt = RUN4;
			RUN4: begin
				// counter was decremented back in RUN1
				if (burst_zero)
					state_nxt = CHECKSUM1;
				else
					state_nxt = RUN1;
			end
			CHECKSUM1: state_nxt = CHECKSUM2;
			CHECKSUM2: state_nxt = DDR3_WAIT;
			DDR3_WAIT: if (!sync.ddr3_busy) state_nxt = DONE;  // let the writer drain the fill
			DONE:      if (!armed_trig) state_nxt = IDLE;  // hold done until trigger drops
			default:   state_nxt = IDLE;  // illegal code, recover
		endcase
	end

	// strobes decoded from the next state, registered below
	always_comb begin
		ctrl_nxt = '{
			fill_size_latch: 1'b0,
			burst_init:      1'b0,
			burst_dec:       1'b0,
			addr_inc:        1'b0,
			fill_inc:        1'b0,
			dummy_reset:     1'b0,
			word_kind:       WORD_DATA,
			out_valid:       1'b0,
			done:            1'b0,
			idle:            1'b0
		};
		case (state_nxt)
			IDLE: begin
				ctrl_nxt.idle        = 1'b1;
				ctrl_nxt.dummy_reset = 1'b1;  // dummy data restarts at 0 each fill
			end
			INIT1: ctrl_nxt.fill_size_latch = 1'b1;  // pick size by fill type
			INIT2: begin
				ctrl_nxt.burst_init = 1'b1;
				ctrl_nxt.word_kind  = WORD_HEADER;
			end
			INIT3: begin
				ctrl_nxt.out_valid = 1'b1;  // header goes out
				ctrl_nxt.addr_inc  = 1'b1;
			end
			RUN1: begin
				ctrl_nxt.burst_dec = 1'b1;
				ctrl_nxt.addr_inc  = 1'b1;
			end
			RUN4: ctrl_nxt.out_valid = 1'b1;  // one data word per burst
			CHECKSUM1: ctrl_nxt.word_kind = WORD_CHECKSUM;
			CHECKSUM2: begin
				ctrl_nxt.out_valid = 1'b1;
				ctrl_nxt.addr_inc  = 1'b1;
				ctrl_nxt.fill_inc  = 1'b1;  // fill is complete here
			end
			DONE: ctrl_nxt.done = 1'b1;
			default: ;  // RUN2, RUN3, DDR3_WAIT carry no strobes
		endcase
	end

	always_ff @(posedge clk) begin
		if (adc_acq_full_reset) begin
			ctrl <= '{
				fill_size_latch: 1'b0,
				burst_init:      1'b0,
				burst_dec:       1'b0,
				addr_inc:        1'b0,
				fill_inc:        1'b0,
				dummy_reset:     1'b0,
				word_kind:       WORD_DATA,
				out_valid:       1'b0,
				done:            1'b0,
				idle:            1'b1  // reset lands in IDLE
			};
		end else begin
			ctrl <= ctrl_nxt;
		end
	end

endmodule

/* source/adc_acq_burst_fmt.sv */
`timescale 1ns/1ps
`include "adc_acq_params.svh"

module adc_acq_burst_fmt
	import adc_acq_pkg::*;
(
	input  logic                        clk,
	input  logic                        adc_acq_full_reset,
	input  acq_ctrl_t                   ctrl,
	input  acq_sync_t                   sync,
	input  logic [`ADC_ACQ_BURST_W-1:0] fill_size1,
	input  logic [`ADC_ACQ_BURST_W-1:0] fill_size2,
	input  logic [`ADC_ACQ_BURST_W-1:0] fill_size3,
	input  logic                        dummy_sel,  // counter data instead of adc samples
	input  logic [`ADC_ACQ_DAT_W-1:0]   adc_dat,
	output logic                        burst_zero,
	output logic [`ADC_ACQ_FILL_W-1:0]  fill_count,
	output acq_word_t                   word
);

	fill_type_t                  type_q;     // fill type latched at INIT1
	logic [`ADC_ACQ_BURST_W-1:0] size_q;     // size latched at INIT1
	logic [`ADC_ACQ_BURST_W-1:0] burst_cnt;
	logic [`ADC_ACQ_ADDR_W-1:0]  addr_cnt;   // next free address
	logic [`ADC_ACQ_ADDR_W-1:0]  addr_q;     // address taken by the last increment
	logic [`ADC_ACQ_DAT_W-1:0]   dummy_cnt;
	logic [`ADC_ACQ_DAT_W-1:0]   sum_q;      // running checksum of the fill
	logic [`ADC_ACQ_DAT_W-1:0]   word_dat;   // mux output
	word_kind_t                  kind_q;     // kind chosen one state earlier
	logic                        out_valid_q;
	word_kind_t                  out_kind;
	logic [`ADC_ACQ_ADDR_W-1:0]  out_addr;
	logic [`ADC_ACQ_DAT_W-1:0]   out_data;

	assign burst_zero = (burst_cnt == '0);

	// word mux
	always_comb begin
		case (kind_q)
			WORD_HEADER:   word_dat = {type_q, fill_count, size_q};  // 2 + 14 + 16 bits
			WORD_CHECKSUM: word_dat = sum_q;
			default:       word_dat = dummy_sel ? dummy_cnt : adc_dat;
		endcase
	end

	always_ff @(posedge clk) begin
		if (adc_acq_full_reset) begin
			type_q      <= FILL_READOUT;
			size_q      <= '0;
			burst_cnt   <= '0;
			addr_cnt    <= '0;
			addr_q      <= '0;
			fill_count  <= '0;
			dummy_cnt   <= '0;
			sum_q       <= '0;
			kind_q      <= WORD_DATA;
			out_valid_q <= 1'b0;
		end else begin
			kind_q      <= ctrl.word_kind;
			out_valid_q <= ctrl.out_valid;
			if (ctrl.fill_size_latch) begin
				type_q <= sync.fill_type;
				case (sync.fill_type)
					FILL_B:  size_q <= fill_size2;
					FILL_C:  size_q <= fill_size3;
					default: size_q <= fill_size1;  // type A, readout never triggers
				endcase
			end
			if (ctrl.burst_init)
				burst_cnt <= size_q;
			else if (ctrl.burst_dec && !burst_zero)
				burst_cnt <= burst_cnt - 1'b1;  // holds at zero, size 0 acts as 1
			if (ctrl.addr_inc) begin
				addr_q   <= addr_cnt;
				addr_cnt <= addr_cnt + 1'b1;  // runs on across fills
			end
			if (ctrl.fill_inc)
				fill_count <= fill_count + 1'b1;
			if (ctrl.dummy_reset)
				dummy_cnt <= '0;
			else if (ctrl.out_valid && kind_q == WORD_DATA)
				dummy_cnt <= dummy_cnt + 1'b1;  // step once per data word
			// header and data words go into the sum, wraps mod 2^32
			if (ctrl.burst_init)
				sum_q <= '0;
			else if (ctrl.out_valid && kind_q != WORD_CHECKSUM)
				sum_q <= sum_q + word_dat;
		end
	end

	// output word register, payload only moves when a word is emitted
	always_ff @(posedge clk) begin
		if (ctrl.out_valid) begin
			out_kind <= kind_q;
			out_addr <= ctrl.addr_inc ? addr_cnt : addr_q;  // value before its increment
			out_data <= word_dat;
		end
	end

	assign word = '{valid: out_valid_q, kind: out_kind, addr: out_addr, data: out_data};

endmodule

/* source/adc_acq_wb_regs.sv */
`timescale 1ns/1ps
`include "adc_acq_params.svh"

module adc_acq_wb_regs (
	input  logic                         clk,
	input  logic                         adc_acq_full_reset,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [`ADC_ACQ_WB_ADR_W-1:0] wb_adr,
	input  logic [`ADC_ACQ_DAT_W-1:0]    wb_dat_w,
	input  logic [3:0]                   wb_sel,
	output logic [`ADC_ACQ_DAT_W-1:0]    wb_dat_r,
	output logic                         wb_ack,
	output logic [`ADC_ACQ_BURST_W-1:0]  fill_size1,
	output logic [`ADC_ACQ_BURST_W-1:0]  fill_size2,
	output logic [`ADC_ACQ_BURST_W-1:0]  fill_size3,
	output logic                         dummy_sel,
	input  logic [`ADC_ACQ_FILL_W-1:0]   fill_count,
	input  logic                         sm_idle
);

	logic                      req;     // new cycle, not yet acked
	logic [`ADC_ACQ_DAT_W-1:0] rd_dat;

	// byte-lane merge for the 16 bit size registers
	function automatic logic [`ADC_ACQ_BURST_W-1:0] merge_size(
		input logic [`ADC_ACQ_BURST_W-1:0] cur,
		input logic [`ADC_ACQ_DAT_W-1:0]   dat,
		input logic [3:0]                  sel
	);
		logic [`ADC_ACQ_BURST_W-1:0] res;
		res = cur;
		if (sel[0]) res[7:0]  = dat[7:0];
		if (sel[1]) res[15:8] = dat[15:8];
		return res;
	endfunction

	assign req = wb_cyc & wb_stb & ~wb_ack;  // ack is a single cycle pulse

	always_comb begin
		case (wb_adr)
			`ADC_ACQ_REG_SIZE1:  rd_dat = {16'd0, fill_size1};
			`ADC_ACQ_REG_SIZE2:  rd_dat = {16'd0, fill_size2};
			`ADC_ACQ_REG_SIZE3:  rd_dat = {16'd0, fill_size3};
			`ADC_ACQ_REG_CTRL:   rd_dat = {31'd0, dummy_sel};
			`ADC_ACQ_REG_STATUS: rd_dat = {15'd0, sm_idle, 2'd0, fill_count};
			default:             rd_dat = '0;  // unmapped
		endcase
	end

	always_ff @(posedge clk) begin
		if (adc_acq_full_reset) begin
			wb_ack     <= 1'b0;
			fill_size1 <= `ADC_ACQ_SIZE_RST;
			fill_size2 <= `ADC_ACQ_SIZE_RST;
			fill_size3 <= `ADC_ACQ_SIZE_RST;
			dummy_sel  <= 1'b0;
		end else begin
			wb_ack <= req;
			if (req && wb_we) begin  // lands as ack goes high
				case (wb_adr)
					`ADC_ACQ_REG_SIZE1: fill_size1 <= merge_size(fill_size1, wb_dat_w, wb_sel);
					`ADC_ACQ_REG_SIZE2: fill_size2 <= merge_size(fill_size2, wb_dat_w, wb_sel);
					`ADC_ACQ_REG_SIZE3: fill_size3 <= merge_size(fill_size3, wb_dat_w, wb_sel);
					`ADC_ACQ_REG_CTRL:  if (wb_sel[0]) dummy_sel <= wb_dat_w[0];
					default: ;  // status is read only
				endcase
			end
		end
	end

	// read data captured with the ack
	always_ff @(posedge clk) begin
		if (req)
			wb_dat_r <= rd_dat;
	end

endmodule

/* source/adc_acq_top.sv */
`timescale 1ns/1ps
`include "adc_acq_params.svh"

module adc_acq_top
	import adc_acq_pkg::*;
(
	input  logic                         clk,
	input  logic                         adc_acq_full_reset,
	input  logic                         acq_enable0,
	input  logic                         acq_enable1,
	input  logic                         acq_trig,
	input  logic                         ddr3_wr_busy,
	input  logic [`ADC_ACQ_DAT_W-1:0]    adc_dat,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [`ADC_ACQ_WB_ADR_W-1:0] wb_adr,
	input  logic [`ADC_ACQ_DAT_W-1:0]    wb_dat_w,
	input  logic [3:0]                   wb_sel,
	output logic [`ADC_ACQ_DAT_W-1:0]    wb_dat_r,
	output logic                         wb_ack,
	output acq_word_t                    out_word,  // to the fifo
	output logic                         acq_done,
	output logic                         sm_idle
);

	acq_sync_t                   sync;
	acq_ctrl_t                   ctrl;
	logic                        burst_zero;
	logic [`ADC_ACQ_BURST_W-1:0] fill_size1;
	logic [`ADC_ACQ_BURST_W-1:0] fill_size2;
	logic [`ADC_ACQ_BURST_W-1:0] fill_size3;
	logic                        dummy_sel;
	logic [`ADC_ACQ_FILL_W-1:0]  fill_count;

	assign acq_done = ctrl.done;
	assign sm_idle  = ctrl.idle;

	adc_acq_decode u_decode (
		.clk(clk), .adc_acq_full_reset(adc_acq_full_reset),
		.acq_enable0(acq_enable0), .acq_enable1(acq_enable1),
		.acq_trig(acq_trig), .ddr3_wr_busy(ddr3_wr_busy),
		.sync(sync)
	);

	adc_acq_sm u_sm (
		.clk(clk), .adc_acq_full_reset(adc_acq_full_reset),
		.sync(sync), .burst_zero(burst_zero), .ctrl(ctrl)
	);

	adc_acq_burst_fmt u_fmt (
		.clk(clk), .adc_acq_full_reset(adc_acq_full_reset),
		.ctrl(ctrl), .sync(sync),
		.fill_size1(fill_size1), .fill_size2(fill_size2), .fill_size3(fill_size3),
		.dummy_sel(dummy_sel), .adc_dat(adc_dat),
		.burst_zero(burst_zero), .fill_count(fill_count), .word(out_word)
	);

	adc_acq_wb_regs u_regs (
		.clk(clk), .adc_acq_full_reset(adc_acq_full_reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.fill_size1(fill_size1), .fill_size2(fill_size2), .fill_size3(fill_size3),
		.dummy_sel(dummy_sel), .fill_count(fill_count), .sm_idle(sm_idle)
	);

endmodule

/* tests/adc_acq_tb.sv */
`timescale 1ns/1ps
`include "adc_acq_params.svh"

module adc_acq_tb
	import adc_acq_pkg::*;
();

	localparam int MAX_CYCLES = 4000;  // the five tests take about 350 cycles
	localparam int WAIT_DONE  = 0;
	localparam int WAIT_IDLE  = 1;
	localparam int WAIT_FILL  = 2;

	logic        clk = 1'b0;
	logic        adc_acq_full_reset;
	logic        acq_enable0, acq_enable1, acq_trig, ddr3_wr_busy;
	logic [31:0] adc_dat;
	logic        wb_cyc, wb_stb, wb_we, wb_ack;
	logic [4:0]  wb_adr;
	logic [31:0] wb_dat_w, wb_dat_r;
	logic [3:0]  wb_sel;
	acq_word_t   out_word;
	logic        acq_done, sm_idle;

	integer      seed = 32'h36594cad;
	int          cycle, errors, err_mark, tests_run, tests_failed;
	logic [31:0] rd;        // scratch read data
	logic [31:0] adc_hist;  // adc sample seen at the last rising edge

	// scoreboard, expected fill and running prediction
	fill_type_t  exp_type;
	logic [15:0] exp_size;
	bit          exp_dummy, fill_open, gap_bad, stray_word;
	int          word_idx, fills_done, last_cyc, gap_got, gap_exp, nbursts;
	logic [23:0] exp_addr;  // runs on across fills
	logic [31:0] run_sum, exp_data, dummy_next;
	word_kind_t  exp_kind;

	adc_acq_top uut (.*);

	always #5 clk = ~clk;

	always @(negedge clk) adc_dat <= $random(seed);  // new sample every cycle
	always @(posedge clk) adc_hist <= adc_dat;

	always @(posedge clk) begin
		cycle++;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// one wishbone classic cycle, held until ack
	task automatic bus_access(input logic we, input logic [4:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, output logic [31:0] rdat);
		int n;
		n        = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		wb_sel   = sel;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < 16);
		if (!wb_ack) begin
			$display("no wishbone ack within 16 cycles at address %h", adr);
			errors++;
		end
		rdat   = wb_dat_r;  // valid with ack
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic read_check(input logic [4:0] adr, input logic [31:0] exp, input string name);
		logic [31:0] rdat;
		bus_access(1'b0, adr, '0, 4'hf, rdat);
		check_val(name, rdat, exp);
	endtask

	// arm the scoreboard, then set the enable pair and raise the trigger
	task automatic start_fill(input fill_type_t ft, input logic [15:0] size, input bit dummy);
		exp_type    = ft;
		exp_size    = size;
		exp_dummy   = dummy;
		word_idx    = 0;
		run_sum     = '0;
		dummy_next  = '0;
		fill_open   = 1'b1;
		acq_enable0 = ft[0];
		acq_enable1 = ft[1];  // enable1 is the high bit of the type
		acq_trig    = 1'b1;
	endtask

	// the checksum word closes the fill before done comes up
	task automatic expect_fill_closed();
		assert (!fill_open) else begin
			$display("acq_done rose before the whole fill was seen");
			errors++;
		end
	endtask

	function automatic bit cond_met(input int what);
		case (what)
			WAIT_DONE: return acq_done;
			WAIT_IDLE: return sm_idle;
			default:   return !fill_open;  // checksum seen
		endcase
	endfunction

	task automatic wait_for(input int what, input int limit);
		int n;
		n = 0;
		while (!cond_met(what) && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!cond_met(what)) begin
			$display("timeout after %0d cycles waiting for condition %0d", limit, what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %0d %s: PASS", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// stream monitor, outputs are stable at the falling edge
	always @(negedge clk) begin
		gap_bad    = 1'b0;
		stray_word = 1'b0;
		if (!adc_acq_full_reset && out_word.valid) begin
			if (!fill_open) begin
				stray_word = 1'b1;
			end else begin
				nbursts = (exp_size == 0) ? 1 : exp_size;  // a zero size still runs one burst
				if (word_idx == 0) begin
					exp_kind = WORD_HEADER;
					exp_data = {exp_type, fills_done[13:0], exp_size};
				end else if (word_idx <= nbursts) begin
					exp_kind = WORD_DATA;
					exp_data = exp_dummy ? dummy_next : adc_hist;
					gap_exp  = 4;
				end else begin
					exp_kind = WORD_CHECKSUM;
					exp_data = run_sum;
					gap_exp  = 2;  // last RUN4 to CHECKSUM2
				end
				if (word_idx != 0) begin
					gap_got = cycle - last_cyc;
					gap_bad = (gap_got != gap_exp);
				end
				check_val("out_word.kind", out_word.kind, exp_kind);
				check_val("out_word.addr", out_word.addr, exp_addr);
				check_val("out_word.data", out_word.data, exp_data);
				run_sum  = run_sum + exp_data;  // predicted words only
				exp_addr = exp_addr + 1'b1;
				last_cyc = cycle;
				word_idx++;
				if (exp_kind == WORD_DATA)
					dummy_next = dummy_next + 1'b1;
				if (exp_kind == WORD_CHECKSUM) begin
					fill_open = 1'b0;
					fills_done++;
				end
			end
		end
	end

	assert property (@(negedge clk) disable iff (adc_acq_full_reset) !(acq_done && sm_idle))
		else begin
			$display("acq_done and sm_idle are high together");
			errors++;
		end

	assert property (@(negedge clk) disable iff (adc_acq_full_reset)
			!(acq_done && out_word.valid))
		else begin
			$display("output word seen while acq_done is high");
			errors++;
		end

	assert property (@(posedge clk) disable iff (adc_acq_full_reset) !gap_bad)
		else begin
			$display("FAIL out_word.valid spacing got %h expected %h", gap_got, gap_exp);
			errors++;
		end

	assert property (@(posedge clk) disable iff (adc_acq_full_reset) !stray_word)
		else begin
			$display("output word seen with no fill in progress");
			errors++;
		end

	initial begin
		adc_acq_full_reset = 1'b1;
		acq_enable0        = 1'b0;
		acq_enable1        = 1'b0;
		acq_trig           = 1'b0;
		ddr3_wr_busy       = 1'b0;
		adc_dat            = '0;
		wb_cyc             = 1'b0;
		wb_stb             = 1'b0;
		wb_we              = 1'b0;
		wb_adr             = '0;
		wb_dat_w           = '0;
		wb_sel             = '0;
		fill_open          = 1'b0;
		exp_addr           = '0;
		fills_done         = 0;
		repeat (8) @(negedge clk);
		adc_acq_full_reset = 1'b0;
		@(negedge clk);

		check_val("sm_idle", sm_idle, 1);
		check_val("acq_done", acq_done, 0);
		check_val("out_word.valid", out_word.valid, 0);
		read_check(`ADC_ACQ_REG_SIZE1, `ADC_ACQ_SIZE_RST, "fill_size1");
		read_check(`ADC_ACQ_REG_SIZE2, `ADC_ACQ_SIZE_RST, "fill_size2");
		read_check(`ADC_ACQ_REG_SIZE3, `ADC_ACQ_SIZE_RST, "fill_size3");
		read_check(`ADC_ACQ_REG_CTRL, 32'h0, "dummy_sel");
		read_check(`ADC_ACQ_REG_STATUS, 32'h0001_0000, "status");
		read_check(5'h14, 32'h0, "wb_dat_r unmapped");
		bus_access(1'b1, `ADC_ACQ_REG_SIZE1, 32'h0000_0003, 4'hf, rd);
		bus_access(1'b1, `ADC_ACQ_REG_SIZE2, 32'h0000_ff02, 4'h1, rd);  // upper lane masked
		bus_access(1'b1, `ADC_ACQ_REG_SIZE3, 32'h0000_0005, 4'hf, rd);
		bus_access(1'b1, `ADC_ACQ_REG_CTRL, 32'h0000_0001, 4'hf, rd);
		read_check(`ADC_ACQ_REG_SIZE1, 32'h3, "fill_size1");
		read_check(`ADC_ACQ_REG_SIZE2, 32'h2, "fill_size2");
		read_check(`ADC_ACQ_REG_SIZE3, 32'h5, "fill_size3");
		read_check(`ADC_ACQ_REG_CTRL, 32'h1, "dummy_sel");
		bus_access(1'b1, `ADC_ACQ_REG_CTRL, 32'h0, 4'hf, rd);  // back to adc samples
		end_test("reset and registers");

		start_fill(FILL_A, 16'd3, 1'b0);
		wait_for(WAIT_DONE, 60);
		expect_fill_closed();
		acq_trig = 1'b0;
		wait_for(WAIT_IDLE, 20);
		end_test("fill A with adc data");

		ddr3_wr_busy = 1'b1;
		start_fill(FILL_A, 16'd3, 1'b0);
		wait_for(WAIT_FILL, 60);
		repeat (20) begin
			@(negedge clk);
			check_val("acq_done", acq_done, 0);  // writer still busy
		end
		ddr3_wr_busy = 1'b0;
		wait_for(WAIT_DONE, 20);
		repeat (10) begin
			@(negedge clk);
			check_val("acq_done", acq_done, 1);  // held while triggered
		end
		acq_trig = 1'b0;
		wait_for(WAIT_IDLE, 20);
		check_val("acq_done", acq_done, 0);
		end_test("ddr3 busy hold-off");

		bus_access(1'b1, `ADC_ACQ_REG_CTRL, 32'h1, 4'hf, rd);
		start_fill(FILL_B, 16'd2, 1'b1);
		wait_for(WAIT_DONE, 60);
		expect_fill_closed();
		acq_trig = 1'b0;
		wait_for(WAIT_IDLE, 20);
		start_fill(FILL_C, 16'd5, 1'b1);
		wait_for(WAIT_DONE, 80);
		expect_fill_closed();
		acq_trig = 1'b0;
		wait_for(WAIT_IDLE, 20);
		end_test("fills B and C with dummy data");

		acq_enable0 = 1'b0;
		acq_enable1 = 1'b0;
		acq_trig    = 1'b1;
		repeat (30) @(negedge clk);
		check_val("sm_idle", sm_idle, 1);
		read_check(`ADC_ACQ_REG_STATUS, 32'h0001_0004, "status");  // idle, four fills
		acq_trig = 1'b0;
		end_test("readout mode ignores trigger");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* list.f */
+incdir+source
source/adc_acq_pkg.sv
source/adc_acq_decode.sv
source/adc_acq_sm.sv
source/adc_acq_burst_fmt.sv
source/adc_acq_wb_regs.sv
source/adc_acq_top.sv
tests/adc_acq_tb.sv

/* Makefile */
# Verilator build and run of the acquisition engine testbench

TOP := adc_acq_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "no result line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
